// File: src/dl_pkg.sv
// Shared widths, word formats and default constants for the ROM download path.
// Modules import this package inside their bodies and use scoped names in port lists.

package dl_pkg;

    // Default sizes, used by dl_top as parameter defaults
    localparam int DEF_MEM_AW     = 8;
    localparam int DEF_FIFO_DEPTH = 4;
    localparam int DEF_WR_CYCLES  = 4;
    localparam int MAX_BURST      = 8;

    // Byte lanes inside one memory word
    localparam int LANE_W  = 3;
    localparam int LANES   = 8;
    localparam int WORD_W  = LANES * 8;
    localparam int BYTE_AW = DEF_MEM_AW + LANE_W;
    localparam int BURST_W = 4;

    typedef logic [BYTE_AW-1:0]    byte_addr_t;
    typedef logic [LANE_W-1:0]     lane_t;
    typedef logic [DEF_MEM_AW-1:0] word_addr_t;
    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [LANES-1:0]      byte_en_t;
    typedef logic [BURST_W-1:0]    burst_len_t;

    // One packed write, data qualified lane by lane
    typedef struct packed {
        word_addr_t addr;
        word_t      data;
        byte_en_t   be;
    } wr_word_t;

    // One burst read request
    typedef struct packed {
        word_addr_t addr;
        burst_len_t len;
    } rd_req_t;

endpackage

// File: src/dl_byte_packer.sv
// Collects loader bytes into masked 64-bit words and pushes them to the write queue.
// Pushes are paid for with credits, which the queue hands back one per popped word.

`timescale 1ns/10ps

module dl_byte_packer #(
    parameter int FIFO_DEPTH = dl_pkg::DEF_FIFO_DEPTH
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               downloading,
    input  logic               ld_wr,
    input  dl_pkg::byte_addr_t ld_addr,
    input  logic [7:0]         ld_data,
    input  logic               credit_ret,
    output logic               ld_ready,
    output logic               push,
    output dl_pkg::wr_word_t   push_word,
    output logic               pending
);
    import dl_pkg::*;

    localparam int CRED_W = $clog2(FIFO_DEPTH + 1);

    logic              started;
    logic              pend_valid;
    word_addr_t        pend_addr;
    word_t             pend_data;
    byte_en_t          pend_be;
    logic [CRED_W-1:0] credits;

    lane_t      in_lane;
    word_addr_t in_addr;
    logic       byte_in;
    logic       same_word;
    logic       new_word;
    logic       cand_valid;
    word_t      cand_data;
    byte_en_t   cand_be;
    logic       need_push;
    logic       has_credit;

    assign in_lane    = ld_addr[LANE_W-1:0];
    assign in_addr    = ld_addr[BYTE_AW-1:LANE_W];
    assign byte_in    = ld_wr && started;
    assign same_word  = !pend_valid || (in_addr == pend_addr);
    assign new_word   = byte_in && !same_word;
    assign has_credit = (credits != '0);

    // Pending word with the incoming byte merged, when it belongs there
    always_comb begin
        cand_data = pend_data;
        cand_be   = pend_be;
        if (byte_in && same_word) begin
            cand_data[in_lane*8 +: 8] = ld_data;
            cand_be[in_lane]          = 1'b1;
        end
    end

    assign cand_valid = pend_valid || (byte_in && same_word);

    // Flush on word change, on a filled top lane, or at the end of the download
    assign need_push = new_word || (cand_valid && (cand_be[LANES-1] || !downloading));

    assign push      = need_push && has_credit;
    assign ld_ready  = started && (!need_push || has_credit);
    assign pending   = pend_valid;

    assign push_word.addr = pend_valid ? pend_addr : in_addr;
    assign push_word.data = cand_data;
    assign push_word.be   = cand_be;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            started    <= 1'b0;
            pend_valid <= 1'b0;
            pend_be    <= '0;
            credits    <= CRED_W'(FIFO_DEPTH);
        end else begin
            started <= 1'b1;
            credits <= credits - CRED_W'(push) + CRED_W'(credit_ret);
            if (push) begin
                // A byte for another word opens the next pending word
                pend_valid <= new_word;
                pend_be    <= new_word ? (byte_en_t'(1) << in_lane) : '0;
            end else if (byte_in && !need_push) begin
                pend_valid <= 1'b1;
                pend_be    <= cand_be;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push && new_word) begin
            pend_addr                 <= in_addr;
            pend_data[in_lane*8 +: 8] <= ld_data;
        end else if (byte_in && !need_push) begin
            pend_addr <= in_addr;
            pend_data <= cand_data;
        end
    end

endmodule

// File: src/dl_credit_fifo.sv
// Circular queue of packed write words between the packer and the memory.
// Each pop returns one credit to the packer, so the queue cannot overflow.

`timescale 1ns/10ps

module dl_credit_fifo #(
    parameter int FIFO_DEPTH = dl_pkg::DEF_FIFO_DEPTH
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             push,
    input  dl_pkg::wr_word_t push_word,
    input  logic             pop,
    output logic             q_valid,
    output dl_pkg::wr_word_t q_word,
    output logic             credit_ret
);
    import dl_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    wr_word_t         slots [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_pop;

    // Pointer step with wrap for any depth
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign do_pop     = pop && q_valid;
    assign q_valid    = (count != '0);
    assign q_word     = slots[rd_ptr];
    assign credit_ret = do_pop;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CNT_W'(push) - CNT_W'(do_pop);
        end
    end

    // Storage, visible at the head one cycle after the push
    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr] <= push_word;
        end
    end

endmodule

// File: src/dl_burst_mem.sv
// Wide word memory fed from the write queue, with byte-masked writes and burst reads.
// Every write keeps the memory busy for WR_CYCLES cycles before the next pop.
// Bursts start only when the download path is fully drained.

`timescale 1ns/10ps

module dl_burst_mem #(
    parameter int MEM_AW    = dl_pkg::DEF_MEM_AW,
    parameter int WR_CYCLES = dl_pkg::DEF_WR_CYCLES
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             q_valid,
    input  dl_pkg::wr_word_t q_word,
    input  logic             downloading,
    input  logic             pending,
    input  logic             rd_valid_in,
    input  dl_pkg::rd_req_t  rd_req,
    output logic             pop,
    output logic             wr_idle,
    output logic             rd_ready,
    output dl_pkg::word_t    rd_data,
    output logic             rd_valid,
    output logic             rd_last
);
    import dl_pkg::*;

    localparam int DEPTH  = 2 ** MEM_AW;
    localparam int BUSY_W = $clog2(WR_CYCLES + 1);

    word_t             mem [DEPTH];
    logic [BUSY_W-1:0] busy_cnt;
    logic [MEM_AW-1:0] wr_addr;
    logic [MEM_AW-1:0] rd_addr;
    burst_len_t        rd_remain;
    burst_len_t        req_len;
    logic              rd_active;
    logic              accept;

    // Contents start cleared and survive reset
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    assign wr_addr  = q_word.addr[MEM_AW-1:0];
    assign pop      = q_valid && (busy_cnt == '0);
    assign wr_idle  = (busy_cnt == '0) && !q_valid;
    assign rd_ready = !downloading && !pending && wr_idle && !rd_active && !rd_valid;
    assign accept   = rd_valid_in && rd_ready;

    // Out of range lengths fall back to the nearest legal burst
    always_comb begin
        req_len = rd_req.len;
        if (req_len == '0) begin
            req_len = burst_len_t'(1);
        end else if (req_len > burst_len_t'(MAX_BURST)) begin
            req_len = burst_len_t'(MAX_BURST);
        end
    end

    // Masked write of the popped word
    always @(posedge clk) begin
        if (pop) begin
            for (int i = 0; i < LANES; i++) begin
                if (q_word.be[i]) begin
                    mem[wr_addr][i*8 +: 8] <= q_word.data[i*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_cnt  <= '0;
            rd_active <= 1'b0;
            rd_addr   <= '0;
            rd_remain <= '0;
            rd_valid  <= 1'b0;
            rd_last   <= 1'b0;
        end else begin
            // Write recovery
            if (pop) begin
                busy_cnt <= BUSY_W'(WR_CYCLES - 1);
            end else if (busy_cnt != '0) begin
                busy_cnt <= busy_cnt - 1'b1;
            end

            // Output stage follows the issue stage by one cycle
            rd_valid <= rd_active;
            rd_last  <= rd_active && (rd_remain == burst_len_t'(1));

            if (accept) begin
                rd_active <= 1'b1;
                rd_addr   <= rd_req.addr[MEM_AW-1:0];
                rd_remain <= req_len;
            end else if (rd_active) begin
                // Address wraps at the memory size
                rd_addr   <= rd_addr + 1'b1;
                rd_remain <= rd_remain - 1'b1;
                if (rd_remain == burst_len_t'(1)) begin
                    rd_active <= 1'b0;
                end
            end
        end
    end

    // Registered read data
    always_ff @(posedge clk) begin
        if (rd_active) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: src/dl_top.sv
// Top level of the download path with the byte packer, credit queue and burst memory.
// Sets the sizes and passes them down to each block.

`timescale 1ns/10ps

module dl_top #(
    parameter int MEM_AW     = dl_pkg::DEF_MEM_AW,
    parameter int FIFO_DEPTH = dl_pkg::DEF_FIFO_DEPTH,
    parameter int WR_CYCLES  = dl_pkg::DEF_WR_CYCLES
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               downloading,
    input  logic               ld_wr,
    input  dl_pkg::byte_addr_t ld_addr,
    input  logic [7:0]         ld_data,
    input  logic               rd_valid_in,
    input  dl_pkg::rd_req_t    rd_req,
    output logic               ld_ready,
    output logic               rd_ready,
    output dl_pkg::word_t      rd_data,
    output logic               rd_valid,
    output logic               rd_last
);
    import dl_pkg::*;

    logic     push;
    wr_word_t push_word;
    logic     pending;
    logic     credit_ret;
    logic     q_valid;
    wr_word_t q_word;
    logic     pop;

    dl_byte_packer #(
        .FIFO_DEPTH ( FIFO_DEPTH )
    ) u_packer (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .ld_wr       ( ld_wr       ),
        .ld_addr     ( ld_addr     ),
        .ld_data     ( ld_data     ),
        .credit_ret  ( credit_ret  ),
        .ld_ready    ( ld_ready    ),
        .push        ( push        ),
        .push_word   ( push_word   ),
        .pending     ( pending     )
    );

    dl_credit_fifo #(
        .FIFO_DEPTH ( FIFO_DEPTH )
    ) u_fifo (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .push       ( push       ),
        .push_word  ( push_word  ),
        .pop        ( pop        ),
        .q_valid    ( q_valid    ),
        .q_word     ( q_word     ),
        .credit_ret ( credit_ret )
    );

    dl_burst_mem #(
        .MEM_AW    ( MEM_AW    ),
        .WR_CYCLES ( WR_CYCLES )
    ) u_mem (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .q_valid     ( q_valid     ),
        .q_word      ( q_word      ),
        .downloading ( downloading ),
        .pending     ( pending     ),
        .rd_valid_in ( rd_valid_in ),
        .rd_req      ( rd_req      ),
        .pop         ( pop         ),
        .wr_idle     (             ),
        .rd_ready    ( rd_ready    ),
        .rd_data     ( rd_data     ),
        .rd_valid    ( rd_valid    ),
        .rd_last     ( rd_last     )
    );

endmodule

// File: verification/tb_clk_gen.sv
// Clock and reset source for the download path testbench.
// Reset is released on a falling edge after RST_CYCLES clock periods.

`timescale 1ns/10ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 100,
    parameter int RST_CYCLES = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// File: verification/dl_burst_chk.sv
// Protocol assertions for the download path, attached to dl_top with bind.
// Queue occupancy is tracked here from push and pop to relate it to ld_ready.

`timescale 1ns/10ps

module dl_burst_chk #(
    parameter int FIFO_DEPTH = dl_pkg::DEF_FIFO_DEPTH
) (
    input logic clk,
    input logic rst_n,
    input logic downloading,
    input logic ld_ready,
    input logic rd_ready,
    input logic rd_valid,
    input logic push,
    input logic pop
);

    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [CNT_W-1:0] q_count;

    // Words held in the queue, pop only happens with a word at the head
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q_count <= '0;
        end else begin
            q_count <= q_count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    a_no_read_in_download : assert property (
        @(posedge clk) disable iff (!rst_n) downloading |-> !rd_valid
    ) else $error("rd_valid is high while a download is running");

    a_busy_not_ready : assert property (
        @(posedge clk) disable iff (!rst_n) rd_valid |-> !rd_ready
    ) else $error("rd_ready is high while burst data is returned");

    // First cycle after reset release is skipped, ld_ready rises one clock later
    a_ready_with_space : assert property (
        @(posedge clk) disable iff (!rst_n)
        ($past(rst_n) && (q_count != CNT_W'(FIFO_DEPTH))) |-> ld_ready
    ) else $error("ld_ready is low although the queue has room");

endmodule

bind dl_top dl_burst_chk #(
    .FIFO_DEPTH ( FIFO_DEPTH )
) u_burst_chk (
    .clk         ( clk         ),
    .rst_n       ( rst_n       ),
    .downloading ( downloading ),
    .ld_ready    ( ld_ready    ),
    .rd_ready    ( rd_ready    ),
    .rd_valid    ( rd_valid    ),
    .push        ( push        ),
    .pop         ( pop         )
);

// File: verification/dl_tb.sv
// Testbench for the ROM download path: random byte downloads and burst reads.
// A byte-array model of the memory predicts every word read back from dl_top.

`timescale 1ns/10ps

module dl_tb;
    import dl_pkg::*;

    localparam int MEM_AW     = DEF_MEM_AW;
    localparam int FIFO_DEPTH = DEF_FIFO_DEPTH;
    localparam int WR_CYCLES  = DEF_WR_CYCLES;
    localparam int MEM_WORDS  = 2 ** MEM_AW;
    localparam int MEM_BYTES  = MEM_WORDS * LANES;
    // About 512 bytes at WR_CYCLES each plus 60 bursts stay far below this
    localparam int MAX_CYCLES = 20000;

    logic       clk;
    logic       rst_n;
    logic       downloading;
    logic       ld_wr;
    byte_addr_t ld_addr;
    logic [7:0] ld_data;
    logic       rd_valid_in;
    rd_req_t    rd_req;
    logic       ld_ready;
    logic       rd_ready;
    word_t      rd_data;
    logic       rd_valid;
    logic       rd_last;

    logic [7:0] model [MEM_BYTES];
    integer     seed   = 71;
    int         cycles = 0;
    int         stalls = 0;

    tb_clk_gen u_clk_gen (
        .clk   ( clk   ),
        .rst_n ( rst_n )
    );

    dl_top #(
        .MEM_AW     ( MEM_AW     ),
        .FIFO_DEPTH ( FIFO_DEPTH ),
        .WR_CYCLES  ( WR_CYCLES  )
    ) dl_top_inst (
        .clk         ( clk         ),
        .rst_n       ( rst_n       ),
        .downloading ( downloading ),
        .ld_wr       ( ld_wr       ),
        .ld_addr     ( ld_addr     ),
        .ld_data     ( ld_data     ),
        .rd_valid_in ( rd_valid_in ),
        .rd_req      ( rd_req      ),
        .ld_ready    ( ld_ready    ),
        .rd_ready    ( rd_ready    ),
        .rd_data     ( rd_data     ),
        .rd_valid    ( rd_valid    ),
        .rd_last     ( rd_last     )
    );

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Result: FAILED");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    task automatic check_eq(input logic [63:0] actual, input logic [63:0] expected,
                            input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, actual,
                     expected);
            $display("Result: FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    // Uniform value in 0 .. n-1
    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    // Expected word, lane i holds the byte at word address * 8 + i
    function automatic word_t model_word(input int waddr);
        word_t w;
        int    base;
        base = (waddr % MEM_WORDS) * LANES;
        for (int i = 0; i < LANES; i++) begin
            w[i*8 +: 8] = model[base + i];
        end
        return w;
    endfunction

    task automatic start_download();
        @(negedge clk);
        downloading = 1'b1;
    endtask

    // Holds the byte until ld_ready, the transfer is on the next rising edge
    task automatic send_byte(input byte_addr_t addr, input logic [7:0] data);
        @(negedge clk);
        ld_wr   = 1'b1;
        ld_addr = addr;
        ld_data = data;
        #1;
        check_eq(64'(rd_ready), 64'd0, "rd_ready during download");
        while (!ld_ready) begin
            stalls++;
            @(negedge clk);
            #1;
        end
        model[addr] = data;
    endtask

    task automatic end_download();
        @(negedge clk);
        ld_wr       = 1'b0;
        downloading = 1'b0;
        #1;
        // Last byte is still pending or queued here
        check_eq(64'(rd_ready), 64'd0, "rd_ready before the writes drain");
    endtask

    task automatic read_burst(input int waddr, input int len);
        word_addr_t start;
        start = word_addr_t'(waddr);
        @(negedge clk);
        rd_valid_in = 1'b1;
        rd_req.addr = start;
        rd_req.len  = burst_len_t'(len);
        #1;
        while (!rd_ready) begin
            @(negedge clk);
            #1;
        end
        // Accepted at the coming rising edge, data starts one cycle later
        @(negedge clk);
        rd_valid_in = 1'b0;
        check_eq(64'(rd_valid), 64'd0, "rd_valid in the cycle after acceptance");
        for (int i = 0; i < len; i++) begin
            @(negedge clk);
            check_eq(64'(rd_valid), 64'd1, "rd_valid during burst");
            check_eq(64'(rd_last), 64'(i == len - 1), "rd_last position");
            check_eq(rd_data, model_word(int'(start) + i), "burst read data");
        end
        @(negedge clk);
        check_eq(64'(rd_valid), 64'd0, "rd_valid after the last word");
    endtask

    task automatic random_bursts(input int count);
        for (int n = 0; n < count; n++) begin
            read_burst(rand_below(MEM_WORDS), rand_below(MAX_BURST) + 1);
        end
    endtask

    initial begin
        downloading = 1'b0;
        ld_wr       = 1'b0;
        ld_addr     = '0;
        ld_data     = '0;
        rd_valid_in = 1'b0;
        rd_req      = '0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            model[i] = 8'h00;
        end

        wait (rst_n === 1'b1);
        #1;
        check_eq(64'(ld_ready), 64'd0, "ld_ready before the first clock");
        check_eq(64'(rd_valid), 64'd0, "rd_valid after reset");
        check_eq(64'(rd_ready), 64'd1, "rd_ready after reset");
        @(negedge clk);
        #1;
        check_eq(64'(ld_ready), 64'd1, "ld_ready after the first clock");

        // Empty memory reads as zero
        random_bursts(10);

        // Sequential download of eight words
        start_download();
        for (int i = 0; i < 64; i++) begin
            send_byte(byte_addr_t'(128 + i), 8'(rand_below(256)));
        end
        end_download();
        read_burst(16, 8);

        // Single bytes over the same words, other lanes must survive
        start_download();
        for (int i = 0; i < 16; i++) begin
            send_byte(byte_addr_t'(128 + rand_below(64)), 8'(rand_below(256)));
        end
        end_download();
        read_burst(16, 8);

        // Scattered bytes, each word costs WR_CYCLES so the queue fills up
        stalls = 0;
        start_download();
        for (int i = 0; i < 400; i++) begin
            send_byte(byte_addr_t'(rand_below(MEM_BYTES)), 8'(rand_below(256)));
        end
        end_download();
        check_eq(64'(stalls != 0), 64'd1, "ld_ready back-pressure seen");
        random_bursts(40);

        // Download across the top of memory, then a burst that wraps
        start_download();
        for (int i = 0; i < 32; i++) begin
            send_byte(byte_addr_t'(MEM_BYTES - 16 + i), 8'(rand_below(256)));
        end
        end_download();
        read_burst(MEM_WORDS - 2, 8);
        read_burst(MEM_WORDS - 1, MAX_BURST);

        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: all.f
src/dl_pkg.sv
src/dl_byte_packer.sv
src/dl_credit_fifo.sv
src/dl_burst_mem.sv
src/dl_top.sv
verification/tb_clk_gen.sv
verification/dl_burst_chk.sv
verification/dl_tb.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the run from its log

verilator --binary --timing --assert --top-module dl_tb -f all.f -o dl_sim \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/dl_sim > sim.log 2>&1 || echo "Simulator returned an error status" >> sim.log
cat sim.log

grep -q "Result: FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "Simulation ended without passing"; exit 1; }
exit 0
